// File: logic/fcore_pkg.sv
// -------------------------------------------------------------------------
// Shared encodings and bundles of the fCore sequencing front end.
// The opcode sits in the low OPCODE_WIDTH bits of every instruction word.
// Address fields are ADDR_WIDTH wide, so PC_WIDTH must not exceed it.
// -------------------------------------------------------------------------
package fcore_pkg;

    localparam int INSTR_WIDTH   = 32;
    localparam int OPCODE_WIDTH  = 5;
    localparam int ADDR_WIDTH    = 12;
    localparam int CHANNEL_WIDTH = 8;
    localparam int IMM_WIDTH     = 16;
    localparam int ROOT_WIDTH    = IMM_WIDTH / 2;

    // Word that closes the metadata and the I/O mapping sections
    localparam logic [INSTR_WIDTH-1:0] SECTION_DELIMITER = 32'h0000_000C;

    typedef enum logic [OPCODE_WIDTH-1:0] {
        NOP  = 5'd0,
        ADD  = 5'd1,
        SUB  = 5'd2,
        MUL  = 5'd3,
        LDC  = 5'd4,
        EFI  = 5'd5,
        STOP = 5'd6
    } opcode_t;

    // One issued instruction for one channel, user carries the program counter
    typedef struct packed {
        logic [INSTR_WIDTH-1:0]   data;
        logic [CHANNEL_WIDTH-1:0] dest;
        logic [ADDR_WIDTH-1:0]    user;
    } issue_beat_t;

    typedef struct packed {
        logic [CHANNEL_WIDTH-1:0] channel;
        logic [ROOT_WIDTH-1:0]    root;
    } efi_result_t;

    typedef struct packed {
        logic [ADDR_WIDTH-1:0]  addr;
        logic [INSTR_WIDTH-1:0] data;
    } prog_write_t;

endpackage

// File: logic/fcore_program_memory.sv
// -------------------------------------------------------------------------
// Program store of 2**PC_WIDTH words with one registered read port.
// Each read returns the word at rd_addr in the low half and the word at
// rd_addr+1 in the high half. The second address wraps at the top.
// PC_WIDTH must not exceed the address field of prog_write_t.
// -------------------------------------------------------------------------
module fcore_program_memory #(
    parameter int PC_WIDTH = 12
) (
    input  logic                                clock,
    input  logic                                rst_n,
    input  logic                                we,
    input  fcore_pkg::prog_write_t              write,
    input  logic [PC_WIDTH-1:0]                 rd_addr,
    output logic [2*fcore_pkg::INSTR_WIDTH-1:0] wide_word
);
    import fcore_pkg::*;

    localparam int DEPTH = 2 ** PC_WIDTH;

    logic [INSTR_WIDTH-1:0] mem [DEPTH];
    logic [PC_WIDTH-1:0]    next_addr;

    // Address of the trailing word, needed by LDC for its constant
    assign next_addr = rd_addr + 1'b1;

    // Loading happens only while the core is idle, the top gates we
    always_ff @(posedge clock) begin
        if (we) begin
            mem[write.addr[PC_WIDTH-1:0]] <= write.data;
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            wide_word <= '0;
        end else begin
            wide_word <= {mem[next_addr], mem[rd_addr]};
        end
    end

endmodule

// File: logic/fcore_efi_sqrt.sv
// -------------------------------------------------------------------------
// Extended function unit computing the integer square root of a 16-bit
// operand. One bit pair is retired per cycle, so done follows start by
// exactly 9 cycles. A start that arrives while busy is dropped.
// -------------------------------------------------------------------------
module fcore_efi_sqrt (
    input  logic                                clock,
    input  logic                                rst_n,
    input  logic                                start,
    input  logic [fcore_pkg::IMM_WIDTH-1:0]     operand,
    input  logic [fcore_pkg::CHANNEL_WIDTH-1:0] channel,
    output logic                                done,
    output fcore_pkg::efi_result_t              result
);
    import fcore_pkg::*;

    localparam int REM_WIDTH  = ROOT_WIDTH + 2;
    localparam int ITER_WIDTH = $clog2(ROOT_WIDTH);
    localparam logic [ITER_WIDTH-1:0] ITER_LAST = ITER_WIDTH'(ROOT_WIDTH - 1);

    logic                     busy;
    logic [ITER_WIDTH-1:0]    iter;
    logic [IMM_WIDTH-1:0]     radicand;
    logic [ROOT_WIDTH-1:0]    root;
    logic [REM_WIDTH-1:0]     rem;
    logic [CHANNEL_WIDTH-1:0] channel_q;
    logic [REM_WIDTH+1:0]     rem_shift;
    logic [REM_WIDTH+1:0]     trial;
    logic [REM_WIDTH+1:0]     rem_diff;
    logic                     fits;

    // Bring down the next bit pair and try 4*root+1 against the remainder
    assign rem_shift = {rem, radicand[IMM_WIDTH-1 -: 2]};
    assign trial     = {2'b00, root, 2'b01};
    assign fits      = rem_shift >= trial;
    assign rem_diff  = rem_shift - trial;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
            iter <= '0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (!busy) begin
                if (start) begin
                    busy <= 1'b1;
                    iter <= '0;
                end
            end else begin
                iter <= iter + 1'b1;
                if (iter == ITER_LAST) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (!busy && start) begin
            radicand  <= operand;
            root      <= '0;
            rem       <= '0;
            channel_q <= channel;
        end else if (busy) begin
            radicand <= radicand << 2;
            root     <= {root[ROOT_WIDTH-2:0], fits};
            // The remainder stays below 2*root+1, so the low bits suffice
            rem      <= fits ? rem_diff[REM_WIDTH-1:0] : rem_shift[REM_WIDTH-1:0];
        end
    end

    // Holds the last root until the next start
    assign result = '{channel: channel_q, root: root};

endmodule

// File: logic/fcore_control_unit.sv
// -------------------------------------------------------------------------
// Sequencer that skips the metadata and I/O mapping sections and then
// issues every code word once per channel before the program counter moves.
// Section words are scanned at one word per two cycles.
// n_channels and program_size are sampled on run. STOP issues no beat.
// A fault is only cleared by reset.
// -------------------------------------------------------------------------
module fcore_control_unit #(
    parameter int PC_WIDTH     = 12,
    parameter int MAX_CHANNELS = 16
) (
    input  logic                                clock,
    input  logic                                rst_n,
    input  logic                                run,
    input  logic [fcore_pkg::CHANNEL_WIDTH-1:0] n_channels,
    input  logic [PC_WIDTH-1:0]                 program_size,
    input  logic [2*fcore_pkg::INSTR_WIDTH-1:0] wide_word,
    input  logic                                efi_done,
    output logic [PC_WIDTH-1:0]                 rd_addr,
    output logic                                issue_valid,
    output fcore_pkg::issue_beat_t              issue_beat,
    output logic [fcore_pkg::INSTR_WIDTH-1:0]   load_data,
    output logic                                efi_start,
    output logic [fcore_pkg::IMM_WIDTH-1:0]     efi_operand,
    output logic [fcore_pkg::CHANNEL_WIDTH-1:0] efi_channel,
    output logic                                done,
    output logic                                fault,
    output logic                                dma_enable
);
    import fcore_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        SEC_METADATA,
        SEC_IO_MAPPING,
        FETCH,
        RUN,
        EFI_CALL,
        FAULT
    } state_t;

    state_t                   state;
    logic [PC_WIDTH-1:0]      pc;
    logic [CHANNEL_WIDTH-1:0] channel;
    logic [CHANNEL_WIDTH-1:0] last_channel;
    logic [PC_WIDTH-1:0]      size_q;
    logic                     pending;

    logic [INSTR_WIDTH-1:0]   word;
    logic [INSTR_WIDTH-1:0]   next_word;
    opcode_t                  opcode;
    logic                     is_stop;
    logic                     is_efi;
    logic                     is_ldc;
    logic                     at_delimiter;
    logic                     at_last_channel;
    logic [PC_WIDTH:0]        pc_plus_one;
    logic [PC_WIDTH:0]        pc_after_instr;
    logic                     beat_fire;
    logic                     efi_fire;

    state_t                   adv_state;
    logic [PC_WIDTH-1:0]      adv_pc;
    logic [CHANNEL_WIDTH-1:0] adv_channel;

    // The memory answers one cycle after rd_addr changes
    assign rd_addr   = pc;
    assign word      = wide_word[INSTR_WIDTH-1:0];
    assign next_word = wide_word[2*INSTR_WIDTH-1:INSTR_WIDTH];
    assign opcode    = opcode_t'(word[OPCODE_WIDTH-1:0]);

    assign is_stop         = opcode == STOP;
    assign is_efi          = opcode == EFI;
    assign is_ldc          = opcode == LDC;
    assign at_delimiter    = word == SECTION_DELIMITER;
    assign at_last_channel = channel == last_channel;

    // One extra bit so that the end of the program is seen without wrap
    assign pc_plus_one    = {1'b0, pc} + 1'b1;
    assign pc_after_instr = {1'b0, pc} + (is_ldc ? 2'd2 : 2'd1);

    // EFI words are issued from EFI_CALL once the unit has answered
    assign beat_fire = (state == RUN && !is_stop && !is_efi)
                     || (state == EFI_CALL && efi_done);
    assign efi_fire  = state == RUN && is_efi;

    assign dma_enable = state == IDLE;
    assign fault      = state == FAULT;

    // Where the sequencer goes after a beat has been issued
    always_comb begin
        adv_state   = RUN;
        adv_pc      = pc;
        adv_channel = channel + 1'b1;
        if (at_last_channel) begin
            adv_channel = '0;
            if (pc_after_instr >= {1'b0, size_q}) begin
                adv_state = FAULT;
            end else begin
                adv_state = FETCH;
                adv_pc    = pc_after_instr[PC_WIDTH-1:0];
            end
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state        <= IDLE;
            pc           <= '0;
            channel      <= '0;
            last_channel <= '0;
            size_q       <= '0;
            pending      <= 1'b0;
            issue_valid  <= 1'b0;
            efi_start    <= 1'b0;
            done         <= 1'b0;
        end else begin
            issue_valid <= beat_fire;
            efi_start   <= efi_fire;
            done        <= 1'b0;
            case (state)
                IDLE: begin
                    if (run) begin
                        pc      <= '0;
                        channel <= '0;
                        pending <= 1'b1;
                        size_q  <= program_size;
                        // A zero count runs one channel, a large one is clamped
                        if (n_channels == '0) begin
                            last_channel <= '0;
                        end else if (n_channels > MAX_CHANNELS) begin
                            last_channel <= CHANNEL_WIDTH'(MAX_CHANNELS - 1);
                        end else begin
                            last_channel <= n_channels - 1'b1;
                        end
                        state <= SEC_METADATA;
                    end
                end
                SEC_METADATA, SEC_IO_MAPPING: begin
                    if (pending) begin
                        pending <= 1'b0;
                    end else begin
                        pending <= 1'b1;
                        if (pc_plus_one >= {1'b0, size_q}) begin
                            state <= FAULT;
                        end else begin
                            pc <= pc_plus_one[PC_WIDTH-1:0];
                            if (at_delimiter) begin
                                state <= (state == SEC_METADATA) ? SEC_IO_MAPPING : FETCH;
                            end
                        end
                    end
                end
                FETCH: begin
                    state <= RUN;
                end
                RUN: begin
                    if (is_stop) begin
                        done  <= 1'b1;
                        state <= IDLE;
                    end else if (is_efi) begin
                        state <= EFI_CALL;
                    end else begin
                        state   <= adv_state;
                        pc      <= adv_pc;
                        channel <= adv_channel;
                    end
                end
                EFI_CALL: begin
                    if (efi_done) begin
                        state   <= adv_state;
                        pc      <= adv_pc;
                        channel <= adv_channel;
                    end
                end
                // FAULT holds, and an unused encoding lands there as well
                default: begin
                    state <= FAULT;
                end
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (beat_fire) begin
            issue_beat.data <= word;
            issue_beat.dest <= channel;
            issue_beat.user <= ADDR_WIDTH'(pc);
            if (is_ldc) begin
                load_data <= next_word;
            end
        end
        if (efi_fire) begin
            efi_operand <= word[INSTR_WIDTH-1 -: IMM_WIDTH];
            efi_channel <= channel;
        end
    end

endmodule

// File: logic/fcore_ctrl_top.sv
// -------------------------------------------------------------------------
// Instruction sequencing front end of the fCore arithmetic core.
// The program may only be written while dma_enable is high.
// Beats have no back-pressure and must be consumed as they appear.
// -------------------------------------------------------------------------
module fcore_ctrl_top #(
    parameter int PC_WIDTH     = 12,
    parameter int MAX_CHANNELS = 16
) (
    input  logic                                clock,
    input  logic                                rst_n,
    input  logic                                prog_we,
    input  fcore_pkg::prog_write_t              prog_write,
    input  logic                                run,
    input  logic [fcore_pkg::CHANNEL_WIDTH-1:0] n_channels,
    input  logic [PC_WIDTH-1:0]                 program_size,
    output logic                                issue_valid,
    output fcore_pkg::issue_beat_t              issue_beat,
    output logic [fcore_pkg::INSTR_WIDTH-1:0]   load_data,
    output logic                                efi_valid,
    output fcore_pkg::efi_result_t              efi_result,
    output logic                                done,
    output logic                                fault,
    output logic                                dma_enable
);
    import fcore_pkg::*;

    logic [PC_WIDTH-1:0]      rd_addr;
    logic [2*INSTR_WIDTH-1:0] wide_word;
    logic                     efi_start;
    logic [IMM_WIDTH-1:0]     efi_operand;
    logic [CHANNEL_WIDTH-1:0] efi_channel;

    fcore_program_memory #(
        .PC_WIDTH(PC_WIDTH)
    ) u_memory (
        .clock    (clock),
        .rst_n    (rst_n),
        .we       (prog_we && dma_enable),
        .write    (prog_write),
        .rd_addr  (rd_addr),
        .wide_word(wide_word)
    );

    fcore_control_unit #(
        .PC_WIDTH    (PC_WIDTH),
        .MAX_CHANNELS(MAX_CHANNELS)
    ) u_control (
        .clock       (clock),
        .rst_n       (rst_n),
        .run         (run),
        .n_channels  (n_channels),
        .program_size(program_size),
        .wide_word   (wide_word),
        .efi_done    (efi_valid),
        .rd_addr     (rd_addr),
        .issue_valid (issue_valid),
        .issue_beat  (issue_beat),
        .load_data   (load_data),
        .efi_start   (efi_start),
        .efi_operand (efi_operand),
        .efi_channel (efi_channel),
        .done        (done),
        .fault       (fault),
        .dma_enable  (dma_enable)
    );

    // Completion of the square root also resumes the sequencer
    fcore_efi_sqrt u_efi (
        .clock  (clock),
        .rst_n  (rst_n),
        .start  (efi_start),
        .operand(efi_operand),
        .channel(efi_channel),
        .done   (efi_valid),
        .result (efi_result)
    );

endmodule

// File: test/fcore_ctrl_assert.sv
// -------------------------------------------------------------------------
// Concurrent checks on the outputs of fcore_ctrl_top, attached by bind.
// n_channels is assumed stable and nonzero while a program runs.
// error_count holds the number of failed assertions.
// -------------------------------------------------------------------------
module fcore_ctrl_assert (
    input logic                                clock,
    input logic                                rst_n,
    input logic                                done,
    input logic                                fault,
    input logic                                issue_valid,
    input logic                                dma_enable,
    input fcore_pkg::issue_beat_t              issue_beat,
    input logic [fcore_pkg::CHANNEL_WIDTH-1:0] n_channels
);
    timeunit 1ns;
    timeprecision 1ps;

    int unsigned error_count = 0;

    done_single_cycle: assert property (@(posedge clock) disable iff (!rst_n)
        done |=> !done)
    else begin
        $error("done stayed high for more than one cycle");
        error_count++;
    end

    // Only a reset may clear the fault flag
    fault_sticky: assert property (@(posedge clock) disable iff (!rst_n)
        fault |=> fault)
    else begin
        $error("fault dropped without a reset");
        error_count++;
    end

    no_issue_when_idle: assert property (@(posedge clock) disable iff (!rst_n)
        !(issue_valid && dma_enable))
    else begin
        $error("a beat was issued while the program port was open");
        error_count++;
    end

    dest_in_range: assert property (@(posedge clock) disable iff (!rst_n)
        issue_valid |-> (issue_beat.dest < n_channels))
    else begin
        $error("a beat was sent to a channel beyond n_channels");
        error_count++;
    end

endmodule

bind fcore_ctrl_top fcore_ctrl_assert i_assert (.*);

// File: test/fcore_ctrl_tb.sv
// -------------------------------------------------------------------------
// Testbench of the fCore sequencing front end. Programs are built here,
// loaded through the write port and checked against a reference walk.
// Outputs are sampled on the falling edge, inputs driven 2 ns after rise.
// -------------------------------------------------------------------------
module fcore_ctrl_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import fcore_pkg::*;

    localparam int PC_WIDTH     = 12;
    localparam int MAX_CHANNELS = 16;

    logic                     clock;
    logic                     rst_n;
    logic                     prog_we;
    prog_write_t              prog_write;
    logic                     run;
    logic [CHANNEL_WIDTH-1:0] n_channels;
    logic [PC_WIDTH-1:0]      program_size;
    logic                     issue_valid;
    issue_beat_t              issue_beat;
    logic [INSTR_WIDTH-1:0]   load_data;
    logic                     efi_valid;
    efi_result_t              efi_result;
    logic                     done;
    logic                     fault;
    logic                     dma_enable;

    logic [INSTR_WIDTH-1:0]   image [256];
    int                       image_size;
    issue_beat_t              exp_beats [$];
    efi_result_t              exp_efi [$];
    logic [INSTR_WIDTH-1:0]   exp_loads [$];
    logic                     exp_fault;
    issue_beat_t              beat_exp;
    efi_result_t              efi_exp;
    int                       efi_seen;
    int                       efi_beats;
    int                       done_count;
    int                       cycle_count;
    int                       budget_cycles;
    integer                   seed;

    fcore_ctrl_top #(
        .PC_WIDTH    (PC_WIDTH),
        .MAX_CHANNELS(MAX_CHANNELS)
    ) i_dut (.*);

    always #10 clock = ~clock;

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("STATUS: FAIL");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_beat(input issue_beat_t got, input issue_beat_t exp);
        if (got !== exp) begin
            fail_run($sformatf("FAILED issue_beat: got %h expected %h", got, exp));
        end
    endtask

    task automatic check_efi(input efi_result_t got, input efi_result_t exp);
        if (got !== exp) begin
            fail_run($sformatf("FAILED efi_result: got %h expected %h", got, exp));
        end
    endtask

    task automatic check_load(input logic [INSTR_WIDTH-1:0] got,
                              input logic [INSTR_WIDTH-1:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("FAILED load_data: got %h expected %h", got, exp));
        end
    endtask

    task automatic check_end(input logic got, input logic exp);
        if (got !== exp) begin
            fail_run($sformatf("FAILED fault at end of run: got %h expected %h", got, exp));
        end
    endtask

    // Smallest r with (r+1)^2 above x, found by counting up
    function automatic logic [ROOT_WIDTH-1:0] int_sqrt(input logic [IMM_WIDTH-1:0] x);
        int r;
        r = 0;
        while ((r + 1) * (r + 1) <= int'(x)) begin
            r++;
        end
        return ROOT_WIDTH'(r);
    endfunction

    // Walks the image as the sequencer should and fills the expected queues
    function automatic void build_expected(input int n_ch, input int size);
        int                     pc;
        int                     section;
        int                     step;
        logic [INSTR_WIDTH-1:0] w;
        opcode_t                op;
        exp_beats.delete();
        exp_efi.delete();
        exp_loads.delete();
        exp_fault = 1'b0;
        pc = 0;
        section = 0;
        while (section < 2) begin
            if (pc + 1 >= size) begin
                exp_fault = 1'b1;
                return;
            end
            if (image[pc] == SECTION_DELIMITER) begin
                section++;
            end
            pc++;
        end
        while (1) begin
            w = image[pc];
            op = opcode_t'(w[OPCODE_WIDTH-1:0]);
            if (op == STOP) begin
                return;
            end
            for (int ch = 0; ch < n_ch; ch++) begin
                if (op == EFI) begin
                    exp_efi.push_back('{channel: CHANNEL_WIDTH'(ch), root: int_sqrt(w[31:16])});
                end
                exp_beats.push_back('{data: w, dest: CHANNEL_WIDTH'(ch), user: ADDR_WIDTH'(pc)});
                if (op == LDC) begin
                    exp_loads.push_back(image[pc + 1]);
                end
            end
            step = (op == LDC) ? 2 : 1;
            if (pc + step >= size) begin
                exp_fault = 1'b1;
                return;
            end
            pc += step;
        end
    endfunction

    task automatic build_program(input int meta_len, input int io_len, input int n_instr,
                                 input bit with_stop, input int first_op);
        opcode_t                ops [6] = '{NOP, ADD, LDC, EFI, SUB, MUL};
        opcode_t                op;
        logic [INSTR_WIDTH-1:0] rnd;
        int                     pc;
        pc = 0;
        // Bit 31 keeps section words away from the delimiter
        repeat (meta_len) begin
            image[pc] = $random(seed) | 32'h8000_0000;
            pc++;
        end
        image[pc] = SECTION_DELIMITER;
        pc++;
        repeat (io_len) begin
            image[pc] = $random(seed) | 32'h8000_0000;
            pc++;
        end
        image[pc] = SECTION_DELIMITER;
        pc++;
        for (int i = 0; i < n_instr; i++) begin
            op = ops[(i + first_op) % 6];
            rnd = $random(seed);
            image[pc] = {rnd[INSTR_WIDTH-1:OPCODE_WIDTH], op};
            pc++;
            if (op == LDC) begin
                image[pc] = $random(seed);
                pc++;
            end
        end
        if (with_stop) begin
            rnd = $random(seed);
            image[pc] = {rnd[INSTR_WIDTH-1:OPCODE_WIDTH], STOP};
            pc++;
        end
        image_size = pc;
    endtask

    task automatic load_program();
        if (!dma_enable) begin
            fail_run("Program load attempted while the core was not idle");
        end
        for (int a = 0; a < image_size; a++) begin
            @(posedge clock);
            #2;
            prog_we = 1'b1;
            prog_write = '{addr: ADDR_WIDTH'(a), data: image[a]};
        end
        @(posedge clock);
        #2;
        prog_we = 1'b0;
    endtask

    task automatic apply_reset();
        @(posedge clock);
        #2;
        rst_n = 1'b0;
        repeat (5) @(posedge clock);
        #2;
        rst_n = 1'b1;
    endtask

    task automatic run_program(input int meta_len, input int io_len, input int n_instr,
                               input bit with_stop, input int first_op, input int n_ch);
        build_program(meta_len, io_len, n_instr, with_stop, first_op);
        load_program();
        build_expected(n_ch, image_size);
        budget_cycles += image_size * n_ch * 40;
        efi_seen = 0;
        efi_beats = 0;
        done_count = 0;
        @(posedge clock);
        #2;
        n_channels = CHANNEL_WIDTH'(n_ch);
        program_size = PC_WIDTH'(image_size);
        run = 1'b1;
        @(posedge clock);
        #2;
        run = 1'b0;
        do @(negedge clock); while (!done && !fault);
        check_end(fault, exp_fault);
        // Idle time in which any stray beat or second done would show up
        repeat (30) @(negedge clock);
        if (exp_beats.size() != 0 || exp_efi.size() != 0 || exp_loads.size() != 0) begin
            fail_run("Run ended with expected beats or EFI results still missing");
        end
        if (!exp_fault && (done_count != 1 || !dma_enable)) begin
            fail_run("done did not pulse exactly once or the core did not return to idle");
        end
        if (exp_fault && !fault) begin
            fail_run("fault flag dropped after the program ran past its end");
        end
    endtask

    always @(negedge clock) begin
        if (i_dut.i_assert.error_count != 0) begin
            fail_run("A bound assertion on the DUT outputs failed");
        end
        if (rst_n) begin
            if (efi_valid) begin
                if (exp_efi.size() == 0) begin
                    fail_run("EFI result arrived that the program does not call for");
                end else begin
                    efi_exp = exp_efi.pop_front();
                    check_efi(efi_result, efi_exp);
                    efi_seen++;
                end
            end
            if (issue_valid) begin
                if (exp_beats.size() == 0) begin
                    fail_run("Beat issued that the program does not call for");
                end else begin
                    beat_exp = exp_beats.pop_front();
                    check_beat(issue_beat, beat_exp);
                    if (opcode_t'(beat_exp.data[OPCODE_WIDTH-1:0]) == LDC) begin
                        check_load(load_data, exp_loads.pop_front());
                    end
                    if (opcode_t'(beat_exp.data[OPCODE_WIDTH-1:0]) == EFI) begin
                        efi_beats++;
                        if (efi_seen < efi_beats) begin
                            fail_run("EFI beat issued before its square root result");
                        end
                    end
                end
            end
            if (done) begin
                done_count++;
            end
        end
    end

    // The budget grows with every program that is started
    initial begin
        cycle_count = 0;
        forever begin
            @(posedge clock);
            cycle_count++;
            if (cycle_count > budget_cycles + 2000) begin
                fail_run("Timeout, the run did not finish within its cycle budget");
            end
        end
    end

    initial begin
        seed = 40926;
        budget_cycles = 0;
        clock = 1'b0;
        rst_n = 1'b0;
        prog_we = 1'b0;
        prog_write = '0;
        run = 1'b0;
        n_channels = '0;
        program_size = '0;
        apply_reset();
        @(negedge clock);
        if (!dma_enable || issue_valid || done || fault) begin
            fail_run("Outputs were not in their idle state after reset");
        end
        run_program(3, 1, 8, 1'b1, 0, 3);
        run_program(0, 4, 7, 1'b1, 2, 16);
        run_program(5, 0, 6, 1'b1, 4, 1);
        // No STOP, so the program counter runs into program_size
        run_program(2, 2, 6, 1'b0, 1, 3);
        apply_reset();
        run_program(1, 2, 9, 1'b1, 3, 3);
        if (i_dut.i_assert.error_count == 0) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            fail_run("Bound assertions reported errors during the run");
        end
    end

endmodule

// File: fcore_ctrl_top.f
logic/fcore_pkg.sv
logic/fcore_program_memory.sv
logic/fcore_efi_sqrt.sv
logic/fcore_control_unit.sv
logic/fcore_ctrl_top.sv
test/fcore_ctrl_assert.sv
test/fcore_ctrl_tb.sv

// File: Bender.yml
package:
  name: fcore_ctrl

sources:
  - logic/fcore_pkg.sv
  - logic/fcore_program_memory.sv
  - logic/fcore_efi_sqrt.sv
  - logic/fcore_control_unit.sv
  - logic/fcore_ctrl_top.sv
  - target: test
    files:
      - test/fcore_ctrl_assert.sv
      - test/fcore_ctrl_tb.sv
